// ==== files.f ====
hw/playback_pkg.sv
hw/playback_regs.sv
hw/packet_mem.sv
hw/playback_engine.sv
hw/packet_playback.sv
sim/packet_playback_tb.sv

// ==== sim/packet_playback_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_playback_tb;
    import playback_pkg::*;

    localparam logic [31:0] SEED = 32'ha566_ef91;

    logic                    clk;
    logic                    rst_n;
    logic                    reg_wr;
    logic                    reg_rd;
    logic [REG_ADDR_WID-1:0] reg_addr;
    logic [REG_DATA_WID-1:0] reg_wdata;
    logic [REG_DATA_WID-1:0] reg_rdata;
    logic                    pkt_valid;
    logic                    pkt_ready;
    logic [DATA_WID-1:0]     pkt_data;
    logic                    pkt_eop;
    logic [MTY_WID-1:0]      pkt_mty;
    logic [META_WID-1:0]     pkt_meta;

    // Reference copy of memory and expected stream shape
    logic [7:0]          ref_bytes [PACKET_MEM_SIZE];
    bit                  stream_on;
    int                  exp_len;
    logic [META_WID-1:0] exp_meta;
    int                  word_idx;
    int                  words_seen;
    int                  pkts_seen;
    logic [DATA_WID-1:0] exp_word;
    logic [DATA_WID-1:0] byte_mask;
    int                  nwords;
    int                  cb;

    // Held word for the stability check
    bit                  held;
    logic [DATA_WID-1:0] held_data;
    logic                held_eop;
    logic [MTY_WID-1:0]  held_mty;
    logic [META_WID-1:0] held_meta;

    bit                  ready_rand;
    logic [31:0]         rnd;
    logic [31:0]         rnd_ready;
    int                  errors;
    int                  tests_pass;
    int                  tests_fail;
    int                  watch_cycles;

    packet_playback dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .pkt_valid (pkt_valid),
        .pkt_ready (pkt_ready),
        .pkt_data  (pkt_data),
        .pkt_eop   (pkt_eop),
        .pkt_mty   (pkt_mty),
        .pkt_meta  (pkt_meta)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw(output logic [31:0] v);
        rnd = xorshift(rnd);
        v   = rnd;
    endtask

    task automatic expect_equal(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
        assert (act === exp)
        else
        begin
            errors++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // ==================================================
    // Host register port
    // ==================================================
    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr    <= 1'b0;
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        reg_rd   <= 1'b1;
        reg_addr <= addr;
        @(posedge clk);
        reg_rd   <= 1'b0;
        @(negedge clk);
        data = reg_rdata;
    endtask

    // Fill whole words from address 0 and mirror the bytes
    task automatic load_packet(input int len);
        logic [31:0]         lo;
        logic [31:0]         hi;
        logic [DATA_WID-1:0] word;
        reg_write(REG_MEM_ADDR, 32'd0);
        for (int w = 0; w < (len + 7) / 8; w++)
        begin
            draw(lo);
            draw(hi);
            word = {hi, lo};
            for (int b = 0; b < DATA_BYTE_WID; b++)
                ref_bytes[w*8 + b] = word[8*b +: 8];
            reg_write(REG_MEM_WDATA_LO, lo);
            reg_write(REG_MEM_WDATA_HI, hi);
        end
    endtask

    task automatic wait_done(output logic [31:0] status);
        do
            reg_read(REG_STATUS, status);
        while (!status[STAT_DONE]);
    endtask

    task automatic send_and_check(input int len, input int burst, input bit resend);
        logic [31:0] m;
        logic [31:0] st;
        draw(m);
        exp_len    = len;
        exp_meta   = m;
        word_idx   = 0;
        words_seen = 0;
        pkts_seen  = 0;
        stream_on  = 1'b1;
        reg_write(REG_PKT_LEN, len);
        reg_write(REG_BURST, burst);
        reg_write(REG_META, m);
        reg_write(REG_CONTROL, CMD_SEND);
        // Engine is busy here, so this one is dropped
        if (resend)
            reg_write(REG_CONTROL, CMD_SEND);
        wait_done(st);
        expect_equal("status", 32'h2, st);
        expect_equal("words", ((len + 7) / 8) * burst, words_seen);
        expect_equal("packets", burst, pkts_seen);
        stream_on = 1'b0;
    endtask

    task automatic send_expect_error(input int len, input int burst);
        logic [31:0] st;
        words_seen = 0;
        reg_write(REG_PKT_LEN, len);
        reg_write(REG_BURST, burst);
        reg_write(REG_CONTROL, CMD_SEND);
        wait_done(st);
        expect_equal("status", 32'h6, st);
        expect_equal("words", 0, words_seen);
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        if (errors == errs_at_start)
        begin
            tests_pass++;
            $display("Test %s: pass", name);
        end
        else
        begin
            tests_fail++;
            $display("Test %s: fail", name);
        end
    endtask

    // ==================================================
    // Stream checkers
    // ==================================================
    always @(posedge clk)
    begin
        rnd_ready = xorshift(rnd_ready);
        pkt_ready <= ready_rand ? rnd_ready[0] : 1'b1;
    end

    always @(posedge clk)
    begin
        if (rst_n && pkt_valid && pkt_ready)
        begin
            assert (stream_on)
            else
            begin
                errors++;
                $display("A stream word was accepted at %0t when none was expected", $time);
            end
            nwords    = (exp_len + 7) / 8;
            exp_word  = '0;
            byte_mask = '0;
            for (cb = 0; cb < DATA_BYTE_WID; cb++)
            begin
                if (word_idx*8 + cb < exp_len)
                begin
                    exp_word[8*cb +: 8]  = ref_bytes[word_idx*8 + cb];
                    byte_mask[8*cb +: 8] = 8'hff;
                end
            end
            expect_equal("pkt_data", exp_word, pkt_data & byte_mask);
            expect_equal("pkt_eop", word_idx == nwords - 1, pkt_eop);
            expect_equal("pkt_mty", (word_idx == nwords - 1) ? nwords*8 - exp_len : 0, pkt_mty);
            expect_equal("pkt_meta", exp_meta, pkt_meta);
            words_seen++;
            if (word_idx == nwords - 1)
            begin
                word_idx = 0;
                pkts_seen++;
            end
            else
                word_idx++;
        end
    end

    // Quiet while reset is held
    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            assert (!pkt_valid)
            else
            begin
                errors++;
                $display("pkt_valid was high during reset at %0t", $time);
            end
        end
    end

    // Stable while stalled
    always @(posedge clk)
    begin
        if (held)
        begin
            assert (pkt_valid && (pkt_data === held_data) && (pkt_eop === held_eop) &&
                    (pkt_mty === held_mty) && (pkt_meta === held_meta))
            else
            begin
                errors++;
                $display("A stalled word changed or vanished at %0t", $time);
            end
        end
        held      <= rst_n && pkt_valid && !pkt_ready;
        held_data <= pkt_data;
        held_eop  <= pkt_eop;
        held_mty  <= pkt_mty;
        held_meta <= pkt_meta;
    end

    initial
    begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", watch_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial
    begin
        int          len1;
        int          len2;
        int          burst2;
        int          burst6;
        int          e0;
        logic [31:0] r;

        rst_n      = 1'b0;
        reg_wr     = 1'b0;
        reg_rd     = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        pkt_ready  = 1'b1;
        ready_rand = 1'b0;
        stream_on  = 1'b0;
        errors     = 0;
        tests_pass = 0;
        tests_fail = 0;
        rnd        = SEED;
        rnd_ready  = ~SEED;

        draw(r);
        len1 = 64 + r % 193;
        draw(r);
        len2 = 64 + r % 193;
        draw(r);
        burst2 = 2 + r % 19;
        draw(r);
        burst6 = 2 + r % 19;
        // Back-pressure can stretch each word, plus register traffic
        watch_cycles = 4 * ((len1 + 7) / 8 + (2 * burst2 + burst6) * ((len2 + 7) / 8)) + 20000;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        e0 = errors;
        expect_equal("pkt_valid", 1'b0, pkt_valid);
        reg_read(REG_MEM_SIZE, r);
        expect_equal("reg_rdata", PACKET_MEM_SIZE, r);
        reg_read(REG_META_WID, r);
        expect_equal("reg_rdata", META_WID, r);
        reg_read(REG_STATUS, r);
        expect_equal("status", 32'h0, r);
        finish_test("info", e0);

        e0 = errors;
        words_seen = 0;
        reg_write(REG_CONTROL, CMD_NOP);
        wait_done(r);
        expect_equal("status", 32'h2, r);
        expect_equal("words", 0, words_seen);
        finish_test("nop", e0);

        e0 = errors;
        load_packet(len1);
        send_and_check(len1, 1, 1'b0);
        finish_test("single", e0);

        e0 = errors;
        load_packet(len2);
        send_and_check(len2, burst2, 1'b0);
        finish_test("burst", e0);

        e0 = errors;
        ready_rand = 1'b1;
        send_and_check(len2, burst2, 1'b0);
        ready_rand = 1'b0;
        finish_test("backpressure", e0);

        e0 = errors;
        send_expect_error(0, 1);
        send_expect_error(PACKET_MEM_SIZE + 1, 1);
        send_expect_error(64, 0);
        send_and_check(len2, burst6, 1'b1);
        finish_test("errors", e0);

        $display("Tests passed: %0d, failed: %0d, check errors: %0d",
                 tests_pass, tests_fail, errors);
        if ((tests_fail == 0) && (errors == 0))
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/packet_playback.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_playback (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  reg_wr,
    input  logic                                  reg_rd,
    input  logic [playback_pkg::REG_ADDR_WID-1:0] reg_addr,
    input  logic [playback_pkg::REG_DATA_WID-1:0] reg_wdata,
    output logic [playback_pkg::REG_DATA_WID-1:0] reg_rdata,
    output logic                                  pkt_valid,
    input  logic                                  pkt_ready,
    output logic [playback_pkg::DATA_WID-1:0]     pkt_data,
    output logic                                  pkt_eop,
    output logic [playback_pkg::MTY_WID-1:0]      pkt_mty,
    output logic [playback_pkg::META_WID-1:0]     pkt_meta
);
    import playback_pkg::*;

    // Host write window into memory
    logic                    mem_wr_en;
    logic [MEM_ADDR_WID-1:0] mem_wr_addr;
    logic [DATA_WID-1:0]     mem_wr_data;

    // Command and status
    logic                    cmd_start;
    playback_cmd_e           cmd_op;
    logic [LEN_WID-1:0]      pkt_len;
    logic [BURST_WID-1:0]    burst_len;
    logic [META_WID-1:0]     meta;
    logic                    busy;
    logic                    done;
    logic                    error;

    // Playback reads
    logic                    rd_en;
    logic [MEM_ADDR_WID-1:0] rd_addr;
    logic [DATA_WID-1:0]     rd_data;

    // ==================================================
    // Register block
    // ==================================================
    playback_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .cmd_start   (cmd_start),
        .cmd_op      (cmd_op),
        .pkt_len     (pkt_len),
        .burst_len   (burst_len),
        .meta        (meta),
        .busy        (busy),
        .done        (done),
        .error       (error)
    );

    packet_mem u_mem (
        .clk     (clk),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (mem_wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // ==================================================
    // Playback engine
    // ==================================================
    playback_engine u_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_start (cmd_start),
        .cmd_op    (cmd_op),
        .pkt_len   (pkt_len),
        .burst_len (burst_len),
        .meta      (meta),
        .busy      (busy),
        .done      (done),
        .error     (error),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .pkt_valid (pkt_valid),
        .pkt_ready (pkt_ready),
        .pkt_data  (pkt_data),
        .pkt_eop   (pkt_eop),
        .pkt_mty   (pkt_mty),
        .pkt_meta  (pkt_meta)
    );

endmodule

`default_nettype wire

// ==== hw/playback_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module playback_engine (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  cmd_start,
    input  playback_pkg::playback_cmd_e           cmd_op,
    input  logic [playback_pkg::LEN_WID-1:0]      pkt_len,
    input  logic [playback_pkg::BURST_WID-1:0]    burst_len,
    input  logic [playback_pkg::META_WID-1:0]     meta,
    output logic                                  busy,
    output logic                                  done,
    output logic                                  error,
    output logic                                  rd_en,
    output logic [playback_pkg::MEM_ADDR_WID-1:0] rd_addr,
    input  logic [playback_pkg::DATA_WID-1:0]     rd_data,
    output logic                                  pkt_valid,
    input  logic                                  pkt_ready,
    output logic [playback_pkg::DATA_WID-1:0]     pkt_data,
    output logic                                  pkt_eop,
    output logic [playback_pkg::MTY_WID-1:0]      pkt_mty,
    output logic [playback_pkg::META_WID-1:0]     pkt_meta
);
    import playback_pkg::*;

    engine_state_e           state;

    // Command captured at start
    playback_cmd_e           op_q;
    logic [LEN_WID-1:0]      len_q;
    logic [BURST_WID-1:0]    burst_q;
    logic [META_WID-1:0]     meta_q;
    logic [LEN_WID-1:0]      len_m1;
    logic                    len_bad;
    logic [MEM_ADDR_WID-1:0] last_addr;
    logic [MTY_WID-1:0]      last_mty;

    // Read side
    logic [MEM_ADDR_WID-1:0] rd_addr_q;
    logic [BURST_WID-1:0]    reps_left;
    logic                    reading;
    logic                    rd_pend;
    logic                    rd_pend_eop;
    logic                    issue;
    logic                    issue_last;
    logic [1:0]              credit;

    // Two-entry output buffer
    logic [DATA_WID-1:0]     buf_data [2];
    logic [1:0]              buf_eop;
    logic                    wr_ptr;
    logic                    rd_ptr;
    logic [1:0]              count;
    logic                    pop;
    logic                    final_pop;

    // ==================================================
    // Length decode and flow control
    // ==================================================
    assign len_m1  = len_q - 1'b1;
    assign len_bad = (len_q == '0) || (len_q > LEN_WID'(PACKET_MEM_SIZE)) || (burst_q == '0);

    // Buffered words plus the one in flight must fit in two slots
    assign credit     = count + {1'b0, rd_pend};
    assign pop        = pkt_valid && pkt_ready;
    assign issue      = (state == PLAY) && reading && ((credit < 2'd2) || pop);
    assign issue_last = (rd_addr_q == last_addr);
    assign final_pop  = pop && pkt_eop && !reading && !rd_pend && (count == 2'd1);

    // ==================================================
    // Control FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= IDLE;
            done        <= 1'b0;
            error       <= 1'b0;
            reading     <= 1'b0;
            rd_pend     <= 1'b0;
            rd_pend_eop <= 1'b0;
            rd_addr_q   <= '0;
            reps_left   <= '0;
            count       <= '0;
            wr_ptr      <= 1'b0;
            rd_ptr      <= 1'b0;
            buf_eop     <= '0;
        end
        else
        begin
            done    <= 1'b0;
            error   <= 1'b0;
            rd_pend <= issue;
            count   <= count + {1'b0, rd_pend} - {1'b0, pop};
            if (rd_pend)
            begin
                buf_eop[wr_ptr] <= rd_pend_eop;
                wr_ptr          <= ~wr_ptr;
            end
            if (pop)
                rd_ptr <= ~rd_ptr;
            // Wrap to word 0 at the end of each repetition
            if (issue)
            begin
                rd_pend_eop <= issue_last;
                if (issue_last)
                begin
                    rd_addr_q <= '0;
                    reps_left <= reps_left - 1'b1;
                    if (reps_left == BURST_WID'(1))
                        reading <= 1'b0;
                end
                else
                    rd_addr_q <= rd_addr_q + 1'b1;
            end
            case (state)
                IDLE:
                    if (cmd_start)
                        state <= CHECK;
                CHECK:
                begin
                    state <= FINISH;
                    done  <= 1'b1;
                    case (op_q)
                        CMD_NOP:  ;
                        CMD_SEND:
                        begin
                            if (len_bad)
                                error <= 1'b1;
                            else
                            begin
                                state     <= PLAY;
                                done      <= 1'b0;
                                reading   <= 1'b1;
                                rd_addr_q <= '0;
                                reps_left <= burst_q;
                            end
                        end
                        default:  error <= 1'b1;
                    endcase
                end
                PLAY:
                    if (final_pop)
                    begin
                        state <= FINISH;
                        done  <= 1'b1;
                    end
                FINISH:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Captured command and buffered words
    always_ff @(posedge clk)
    begin
        if ((state == IDLE) && cmd_start)
        begin
            op_q    <= cmd_op;
            len_q   <= pkt_len;
            burst_q <= burst_len;
            meta_q  <= meta;
        end
        if (state == CHECK)
        begin
            last_addr <= len_m1[MTY_WID +: MEM_ADDR_WID];
            last_mty  <= ~len_m1[MTY_WID-1:0];
        end
        if (rd_pend)
            buf_data[wr_ptr] <= rd_data;
    end

    // ==================================================
    // Outputs
    // ==================================================
    assign busy      = (state != IDLE);
    assign rd_en     = issue;
    assign rd_addr   = rd_addr_q;
    assign pkt_valid = (count != 2'd0);
    assign pkt_data  = buf_data[rd_ptr];
    assign pkt_eop   = buf_eop[rd_ptr];
    assign pkt_mty   = buf_eop[rd_ptr] ? last_mty : '0;
    assign pkt_meta  = meta_q;

endmodule

`default_nettype wire

// ==== hw/packet_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_mem (
    input  logic                                  clk,
    input  logic                                  wr_en,
    input  logic [playback_pkg::MEM_ADDR_WID-1:0] wr_addr,
    input  logic [playback_pkg::DATA_WID-1:0]     wr_data,
    input  logic                                  rd_en,
    input  logic [playback_pkg::MEM_ADDR_WID-1:0] rd_addr,
    output logic [playback_pkg::DATA_WID-1:0]     rd_data
);
    import playback_pkg::*;

    // ==================================================
    // Storage
    // ==================================================
    logic [DATA_WID-1:0] mem [MEM_DEPTH];

    // Host side write port
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // Playback side read, one cycle of latency
    always_ff @(posedge clk)
    begin
        if (rd_en)
            rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== hw/playback_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module playback_regs (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      reg_wr,
    input  logic                                      reg_rd,
    input  logic [playback_pkg::REG_ADDR_WID-1:0]     reg_addr,
    input  logic [playback_pkg::REG_DATA_WID-1:0]     reg_wdata,
    output logic [playback_pkg::REG_DATA_WID-1:0]     reg_rdata,
    output logic                                      mem_wr_en,
    output logic [playback_pkg::MEM_ADDR_WID-1:0]     mem_wr_addr,
    output logic [playback_pkg::DATA_WID-1:0]         mem_wr_data,
    output logic                                      cmd_start,
    output playback_pkg::playback_cmd_e               cmd_op,
    output logic [playback_pkg::LEN_WID-1:0]          pkt_len,
    output logic [playback_pkg::BURST_WID-1:0]        burst_len,
    output logic [playback_pkg::META_WID-1:0]         meta,
    input  logic                                      busy,
    input  logic                                      done,
    input  logic                                      error
);
    import playback_pkg::*;

    logic                      ctrl_wr;
    logic                      hi_wr;
    logic [MEM_ADDR_WID-1:0]   mem_addr;
    logic [DATA_WID/2-1:0]     wdata_lo;
    playback_cmd_e             last_op;
    logic                      stat_done;
    logic                      stat_error;
    logic [REG_DATA_WID-1:0]   rd_mux;

    // ==================================================
    // Command path
    // ==================================================
    assign ctrl_wr = reg_wr && (reg_addr == REG_CONTROL);
    assign hi_wr   = reg_wr && (reg_addr == REG_MEM_WDATA_HI);

    // Control writes while the engine runs are dropped
    assign cmd_start = ctrl_wr && !busy;
    assign cmd_op    = playback_cmd_e'(reg_wdata[$bits(playback_cmd_e)-1:0]);

    // ==================================================
    // Configuration and status registers
    // ==================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pkt_len     <= '0;
            burst_len   <= '0;
            meta        <= '0;
            mem_addr    <= '0;
            mem_wr_en   <= 1'b0;
            mem_wr_addr <= '0;
            last_op     <= CMD_NOP;
            stat_done   <= 1'b0;
            stat_error  <= 1'b0;
        end
        else
        begin
            mem_wr_en <= 1'b0;
            if (reg_wr)
            begin
                case (reg_addr)
                    REG_PKT_LEN:  pkt_len   <= reg_wdata[LEN_WID-1:0];
                    REG_BURST:    burst_len <= reg_wdata[BURST_WID-1:0];
                    REG_META:     meta      <= reg_wdata[META_WID-1:0];
                    REG_MEM_ADDR: mem_addr  <= reg_wdata[MEM_ADDR_WID-1:0];
                    default:      ;
                endcase
            end
            // High half commits the word and steps the address
            if (hi_wr)
            begin
                mem_wr_en   <= 1'b1;
                mem_wr_addr <= mem_addr;
                mem_addr    <= mem_addr + 1'b1;
            end
            // Sticky bits cleared by an accepted command
            if (cmd_start)
            begin
                last_op    <= cmd_op;
                stat_done  <= 1'b0;
                stat_error <= 1'b0;
            end
            else
            begin
                if (done)
                    stat_done <= 1'b1;
                if (error)
                    stat_error <= 1'b1;
            end
        end
    end

    // Data window halves
    always_ff @(posedge clk)
    begin
        if (reg_wr && (reg_addr == REG_MEM_WDATA_LO))
            wdata_lo <= reg_wdata;
        if (hi_wr)
            mem_wr_data <= {reg_wdata, wdata_lo};
    end

    // ==================================================
    // Read side
    // ==================================================
    always_comb
    begin
        rd_mux = '0;
        case (reg_addr)
            REG_MEM_SIZE: rd_mux = REG_DATA_WID'(PACKET_MEM_SIZE);
            REG_META_WID: rd_mux = REG_DATA_WID'(META_WID);
            REG_CONTROL:  rd_mux = REG_DATA_WID'(last_op);
            REG_STATUS:
            begin
                rd_mux[STAT_BUSY]  = busy;
                rd_mux[STAT_DONE]  = stat_done;
                rd_mux[STAT_ERROR] = stat_error;
            end
            REG_PKT_LEN:  rd_mux = REG_DATA_WID'(pkt_len);
            REG_BURST:    rd_mux = REG_DATA_WID'(burst_len);
            REG_META:     rd_mux = REG_DATA_WID'(meta);
            REG_MEM_ADDR: rd_mux = REG_DATA_WID'(mem_addr);
            // Data window is write-only
            default:      rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            reg_rdata <= '0;
        else if (reg_rd)
            reg_rdata <= rd_mux;
    end

endmodule

`default_nettype wire

// ==== hw/playback_pkg.sv ====
`default_nettype none

package playback_pkg;

    // ==================================================
    // Stream and memory sizes
    // ==================================================
    localparam int DATA_BYTE_WID   = 8;
    localparam int DATA_WID        = DATA_BYTE_WID * 8;
    localparam int MTY_WID         = $clog2(DATA_BYTE_WID);
    localparam int PACKET_MEM_SIZE = 2048;
    localparam int MEM_DEPTH       = PACKET_MEM_SIZE / DATA_BYTE_WID;
    localparam int MEM_ADDR_WID    = $clog2(MEM_DEPTH);
    localparam int META_WID        = 32;
    localparam int LEN_WID         = 16;
    localparam int BURST_WID       = 16;

    // ==================================================
    // Register map
    // ==================================================
    localparam int REG_ADDR_WID = 8;
    localparam int REG_DATA_WID = 32;

    localparam logic [REG_ADDR_WID-1:0] REG_MEM_SIZE     = 8'h00;
    localparam logic [REG_ADDR_WID-1:0] REG_META_WID     = 8'h04;
    localparam logic [REG_ADDR_WID-1:0] REG_CONTROL      = 8'h08;
    localparam logic [REG_ADDR_WID-1:0] REG_STATUS       = 8'h0C;
    localparam logic [REG_ADDR_WID-1:0] REG_PKT_LEN      = 8'h10;
    localparam logic [REG_ADDR_WID-1:0] REG_BURST        = 8'h14;
    localparam logic [REG_ADDR_WID-1:0] REG_META         = 8'h18;
    localparam logic [REG_ADDR_WID-1:0] REG_MEM_ADDR     = 8'h1C;
    localparam logic [REG_ADDR_WID-1:0] REG_MEM_WDATA_LO = 8'h20;
    localparam logic [REG_ADDR_WID-1:0] REG_MEM_WDATA_HI = 8'h24;

    // Status bit positions
    localparam int STAT_BUSY  = 0;
    localparam int STAT_DONE  = 1;
    localparam int STAT_ERROR = 2;

    typedef enum logic [1:0] {
        CMD_NOP  = 2'd0,
        CMD_SEND = 2'd1
    } playback_cmd_e;

    typedef enum logic [1:0] {
        IDLE,
        CHECK,
        PLAY,
        FINISH
    } engine_state_e;

endpackage

`default_nettype wire
